/* bht.sv */
// SETS must not exceed 2**BP_INDEX_WIDTH; one read and one write port, valid bit is not bypassed
`include "bp_config.svh"

module bht #(
    parameter int SETS = `BP_SETS
) (
    input  logic                                      clock,
    input  logic                                      reset_n,
    // Write port, driven by the update queue
    input  logic                                      write_enable,
    input  logic [`BP_INDEX_WIDTH-1:0]                write_index,
    input  logic [`BP_HISTORY_WIDTH-1:0]              write_counter_select,
    input  logic                                      write_inc,
    input  logic                                      write_dec,
    input  logic                                      valid_in,
    // Read port, driven by the predict path
    input  logic                                      read_enable,
    input  logic [`BP_INDEX_WIDTH-1:0]                read_index,
    output logic [bp_counter_pkg::SET_DATA_WIDTH-1:0] read_data,
    output logic                                      read_valid,
    output logic [31:0]                               read_miss_count
);

    import bp_counter_pkg::*;

    logic           valid_mem [SETS];             // One valid bit per set
    counter_state_t read_next [COUNTERS_PER_SET]; // Set contents after bypass

    ////////////////////////////////////////////////////////////////////////////
    // Counter lanes, one array per counter position
    ////////////////////////////////////////////////////////////////////////////

    for (genvar lane = 0; lane < COUNTERS_PER_SET; lane++) begin : g_lane
        counter_state_t lane_mem [SETS];
        counter_state_t lane_new;
        logic           lane_write;

        // Inc and dec together (invalidate) leave the counter alone
        assign lane_write = write_enable
                         && (write_counter_select == `BP_HISTORY_WIDTH'(lane))
                         && (write_inc ^ write_dec);

        assign lane_new = write_inc ? counter_inc(lane_mem[write_index])
                                    : counter_dec(lane_mem[write_index]);

        always_ff @(posedge clock or negedge reset_n) begin
            if (!reset_n) begin
                for (int s = 0; s < SETS; s++) begin
                    lane_mem[s] <= strong_not_taken;
                end
            end else if (lane_write) begin
                lane_mem[write_index] <= lane_new;
            end
        end

        // Same-cycle write to the read set forwards the new value
        assign read_next[lane] = (lane_write && (write_index == read_index))
                               ? lane_new : lane_mem[read_index];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Valid bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= 1'b0;
            end
        end else if (write_enable) begin
            valid_mem[write_index] <= valid_in;  // Training sets it, invalidate clears it
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registered read and miss count
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            read_data       <= '0;
            read_valid      <= 1'b0;
            read_miss_count <= '0;
        end else if (read_enable) begin
            read_data  <= {read_next[3], read_next[2], read_next[1], read_next[0]};
            read_valid <= valid_mem[read_index];  // Pre-write value on a same-set write
            if (!valid_mem[read_index]) begin
                read_miss_count <= read_miss_count + 32'd1;
            end
        end
        // Without a read the last result is held
    end

    // A write with an unknown select would silently skip every lane
    assert property (@(posedge clock) disable iff (!reset_n)
        write_enable |-> !$isunknown(write_counter_select))
        else $error("bht: write_counter_select unknown during a write");

endmodule

/* bp_config.svh */
// Only the set count is meant to change; 2**BP_HISTORY_WIDTH must equal the four counters per set
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Table geometry
////////////////////////////////////////////////////////////////////////////

`define BP_SETS 512            // Sets in the branch history table
`define BP_INDEX_WIDTH 9       // Must cover BP_SETS

// Two history bits pick one of the four counters in a set
`define BP_HISTORY_WIDTH 2

////////////////////////////////////////////////////////////////////////////
// Update path
////////////////////////////////////////////////////////////////////////////

`define BP_UPDATE_CREDITS 4    // Queue depth and initial sender credits

`endif

/* bp_counter_pkg.sv */
// Counter layout is fixed at four 2-bit counters per set; the top counter bit is the direction
package bp_counter_pkg;

    localparam int COUNTER_WIDTH = 2;
    localparam int COUNTERS_PER_SET = 4;
    localparam int SET_DATA_WIDTH = COUNTER_WIDTH * COUNTERS_PER_SET;  // Counter 0 in the LSBs

    typedef enum logic [COUNTER_WIDTH-1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_state_t;

    // Saturating step toward taken
    function automatic counter_state_t counter_inc(input counter_state_t state);
        return (state == strong_taken) ? state : counter_state_t'(state + 2'd1);
    endfunction

    function automatic counter_state_t counter_dec(input counter_state_t state);
        return (state == strong_not_taken) ? state : counter_state_t'(state - 2'd1);
    endfunction

    function automatic logic counter_taken(input counter_state_t state);
        return state[COUNTER_WIDTH-1];  // Upper half of the range predicts taken
    endfunction

endpackage

/* bp_update_pkg.sv */
// Training message opcodes; encoding 2'b11 is unused and is handled like an invalidate
package bp_update_pkg;

    localparam int UPDATE_OP_WIDTH = 2;

    typedef enum logic [UPDATE_OP_WIDTH-1:0] {
        op_train_taken     = 2'd0,  // Counter one step toward taken, set valid
        op_train_not_taken = 2'd1,  // Counter one step toward not taken, set valid
        op_invalidate      = 2'd2   // Clear the valid bit, counters kept
    } update_op_t;

    // Training ops move the global history, invalidations do not
    function automatic logic op_trains(input update_op_t op);
        return (op == op_train_taken) || (op == op_train_not_taken);
    endfunction

endpackage

/* branch_predictor.sv */
// Direction only, no target; update sender starts with BP_UPDATE_CREDITS credits
`include "bp_config.svh"

module branch_predictor (
    input  logic                                      clock,
    input  logic                                      reset_n,
    // Fetch side
    input  logic                                      predict_valid,
    input  logic [`BP_INDEX_WIDTH-1:0]                predict_index,
    output logic                                      prediction_valid,
    output logic                                      prediction_taken,
    output logic [bp_counter_pkg::SET_DATA_WIDTH-1:0] prediction_counters,
    output logic                                      prediction_hit,
    output logic [31:0]                               read_miss_count,
    // Resolved branches from execute
    input  logic                                      update_valid,
    input  logic [`BP_INDEX_WIDTH-1:0]                update_index,
    input  logic [`BP_HISTORY_WIDTH-1:0]              update_history,
    input  bp_update_pkg::update_op_t                 update_op,
    output logic                                      update_credit
);

    import bp_counter_pkg::*;

    logic                         write_enable;
    logic [`BP_INDEX_WIDTH-1:0]   write_index;
    logic [`BP_HISTORY_WIDTH-1:0] write_counter_select;
    logic                         write_inc;
    logic                         write_dec;
    logic                         valid_in;
    logic                         train_taken_pulse;
    logic                         train_taken;
    logic                         read_enable;
    logic [`BP_INDEX_WIDTH-1:0]   read_index;
    logic [SET_DATA_WIDTH-1:0]    read_data;
    logic                         read_valid;

    update_queue u_update_queue (
        .clock, .reset_n,
        .update_valid, .update_index, .update_history, .update_op, .update_credit,
        .write_enable, .write_index, .write_counter_select,
        .write_inc, .write_dec, .valid_in,
        .train_taken_pulse, .train_taken
    );

    bht #(.SETS(`BP_SETS)) u_bht (
        .clock, .reset_n,
        .write_enable, .write_index, .write_counter_select,
        .write_inc, .write_dec, .valid_in,
        .read_enable, .read_index, .read_data, .read_valid, .read_miss_count
    );

    predict_select u_predict_select (
        .clock, .reset_n,
        .predict_valid, .predict_index,
        .read_data, .read_valid,
        .train_taken_pulse, .train_taken,
        .read_enable, .read_index,
        .prediction_valid, .prediction_taken, .prediction_counters, .prediction_hit
    );

endmodule

/* compile.f */
+incdir+.
bp_counter_pkg.sv
bp_update_pkg.sv
bht.sv
update_queue.sv
predict_select.sv
branch_predictor.sv
tb_branch_predictor.sv

/* predict_select.sv */
// History and read set are taken in the request cycle; outputs other than valid hold between reads
`include "bp_config.svh"

module predict_select (
    input  logic                                      clock,
    input  logic                                      reset_n,
    input  logic                                      predict_valid,
    input  logic [`BP_INDEX_WIDTH-1:0]                predict_index,
    input  logic [bp_counter_pkg::SET_DATA_WIDTH-1:0] read_data,
    input  logic                                      read_valid,
    input  logic                                      train_taken_pulse,
    input  logic                                      train_taken,
    output logic                                      read_enable,
    output logic [`BP_INDEX_WIDTH-1:0]                read_index,
    output logic                                      prediction_valid,
    output logic                                      prediction_taken,
    output logic [bp_counter_pkg::SET_DATA_WIDTH-1:0] prediction_counters,
    output logic                                      prediction_hit
);

    import bp_counter_pkg::*;

    logic [`BP_HISTORY_WIDTH-1:0] global_history;   // Newest outcome in bit 0
    logic [`BP_HISTORY_WIDTH-1:0] request_history;  // History that goes with the read in flight
    counter_state_t               selected_counter;

    // The table read is issued in the request cycle
    assign read_enable = predict_valid;
    assign read_index  = predict_index;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            global_history <= '0;
        end else if (train_taken_pulse) begin
            global_history <= {global_history[`BP_HISTORY_WIDTH-2:0], train_taken};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request pipeline, one stage to line up with the table read
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            prediction_valid <= 1'b0;
            request_history  <= '0;
        end else begin
            prediction_valid <= predict_valid;
            if (predict_valid) begin
                request_history <= global_history;  // Pre-shift value on a same-cycle drain
            end
        end
    end

    assign selected_counter = counter_state_t'(
        read_data[request_history * COUNTER_WIDTH +: COUNTER_WIDTH]);

    assign prediction_taken    = counter_taken(selected_counter);
    assign prediction_counters = read_data;
    assign prediction_hit      = read_valid;

    // Fetch relies on a fixed one-cycle answer
    assert property (@(posedge clock) disable iff (!reset_n)
        prediction_valid == $past(predict_valid))
        else $error("predict_select: prediction_valid not one cycle after predict_valid");

endmodule

/* tb_branch_predictor.sv */
// Needs BP_SETS above 12 and BP_HISTORY_WIDTH of 2; opcode 2'b11 is never sent to the DUT
`include "bp_config.svh"

module tb_branch_predictor;
    timeunit 1ns;
    timeprecision 100ps;

    import bp_update_pkg::*;

    localparam int CREDITS = `BP_UPDATE_CREDITS;
    localparam int RANDOM_CYCLES = 200;
    // Reset, reset reads, saturation, random, bypass, invalidate, bursts, drain
    localparam int STIM_CYCLES = 5 + 10 + 16 + RANDOM_CYCLES + 16 + 9 + 48 + 8;

    logic                         clock = 1'b0;
    logic                         reset_n;
    logic                         predict_valid;
    logic [`BP_INDEX_WIDTH-1:0]   predict_index;
    logic                         prediction_valid;
    logic                         prediction_taken;
    logic [7:0]                   prediction_counters;
    logic                         prediction_hit;
    logic [31:0]                  read_miss_count;
    logic                         update_valid;
    logic [`BP_INDEX_WIDTH-1:0]   update_index;
    logic [`BP_HISTORY_WIDTH-1:0] update_history;
    update_op_t                   update_op;
    logic                         update_credit;
    logic [31:0]                  lfsr_state;
    int                           credits;
    int                           accepted;
    int                           returned;
    int                           value_errors;
    int                           protocol_errors;
    string                        test_name;

    // Reference state and the DUT queue as the model sees it
    logic [1:0]                 model_ctr [`BP_SETS][4];
    logic                       model_valid [`BP_SETS];
    logic [1:0]                 model_history;
    logic [31:0]                model_miss;
    logic [`BP_INDEX_WIDTH-1:0] pend_index [$];
    logic [1:0]                 pend_hist [$];
    update_op_t                 pend_op [$];
    logic [9:0]                 exp_read [$];    // {hit, taken, counters}
    logic [31:0]                exp_miss [$];
    string                      exp_name [$];

    branch_predictor dut0 (.*);

    always #4 clock = ~clock;

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [`BP_INDEX_WIDTH-1:0] pool_index(input logic [1:0] sel);
        return `BP_INDEX_WIDTH'(3 + 3 * sel);  // Sets 3, 6, 9 and 12
    endfunction

    function automatic update_op_t random_op();
        logic [1:0] bits;
        bits = random_bits(2);
        return (bits == 2'd0) ? op_invalidate : (bits[0] ? op_train_taken : op_train_not_taken);
    endfunction

    function automatic logic [1:0] step_counter(input logic [1:0] value, input logic up);
        return up ? ((value == 2'b11) ? value : value + 2'd1)
                  : ((value == 2'b00) ? value : value - 2'd1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Counters see the write of this cycle, valid bit and history do not
    function automatic logic [9:0] expected_read(input logic [`BP_INDEX_WIDTH-1:0] index,
            input logic drain, input logic [`BP_INDEX_WIDTH-1:0] w_index,
            input logic [1:0] w_hist, input update_op_t w_op);
        logic [7:0] lanes;
        for (int lane = 0; lane < 4; lane++) begin
            lanes[lane*2 +: 2] = model_ctr[index][lane];
            if (drain && w_index == index && w_hist == lane && w_op != op_invalidate) begin
                lanes[lane*2 +: 2] = step_counter(model_ctr[index][lane], w_op == op_train_taken);
            end
        end
        return {model_valid[index], lanes[model_history*2+1], lanes};
    endfunction

    always @(posedge clock) begin
        logic                       drain;
        logic [`BP_INDEX_WIDTH-1:0] w_index;
        logic [1:0]                 w_hist;
        update_op_t                 w_op;
        if (reset_n) begin
            drain = (pend_op.size() != 0);  // Head drained in the cycle that ends here
            if (drain) begin
                w_index = pend_index.pop_front();
                w_hist = pend_hist.pop_front();
                w_op = pend_op.pop_front();
            end
            if (predict_valid) begin
                exp_read.push_back(expected_read(predict_index, drain, w_index, w_hist, w_op));
                model_miss += !model_valid[predict_index];
                exp_miss.push_back(model_miss);
                exp_name.push_back(test_name);
            end
            if (drain && w_op == op_invalidate) begin
                model_valid[w_index] = 1'b0;
            end else if (drain) begin
                model_ctr[w_index][w_hist] = step_counter(model_ctr[w_index][w_hist],
                                                          w_op == op_train_taken);
                model_valid[w_index] = 1'b1;
                model_history = {model_history[0], w_op == op_train_taken};
            end
            if (update_valid) begin
                pend_index.push_back(update_index);
                pend_hist.push_back(update_history);
                pend_op.push_back(update_op);
                accepted++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare at mid-cycle where the outputs are settled
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_value(input string name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        value_errors++;
        $display("[FAIL] %s: %s expected %0h actual %0h", name, what, expected, actual);
    endtask

    task automatic protocol_error(input string message);
        protocol_errors++;
        $display("ERROR: %s", message);
    endtask

    task automatic print_counts();
        $display("Errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
    endtask

    always @(negedge clock) begin
        logic [9:0]  exp;
        logic [31:0] miss;
        string       name;
        if (reset_n) begin
            assert (update_credit === (pend_op.size() != 0))
                else report_value(test_name, "update_credit", pend_op.size() != 0, update_credit);
            if (update_credit) begin
                credits++;
                returned++;
                assert (credits <= CREDITS)
                    else protocol_error("credit returned that was never spent");
            end
            if (prediction_valid || exp_read.size() != 0) begin
                assert (prediction_valid === 1'b1 && exp_read.size() == 1)
                    else protocol_error("prediction_valid is not one cycle after the request");
            end
            if (prediction_valid && exp_read.size() != 0) begin
                exp = exp_read.pop_front();
                miss = exp_miss.pop_front();
                name = exp_name.pop_front();
                assert (prediction_counters === exp[7:0])
                    else report_value(name, "prediction_counters", exp[7:0], prediction_counters);
                assert (prediction_hit === exp[9])
                    else report_value(name, "prediction_hit", exp[9], prediction_hit);
                assert (prediction_taken === exp[8])
                    else report_value(name, "prediction_taken", exp[8], prediction_taken);
                assert (read_miss_count === miss)
                    else report_value(name, "read_miss_count", miss, read_miss_count);
            end
            exp_read.delete();  // Stale entries would repeat the same error
            exp_miss.delete();
            exp_name.delete();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive(input logic pv, input logic [`BP_INDEX_WIDTH-1:0] pidx,
                         input logic uv, input logic [`BP_INDEX_WIDTH-1:0] uidx,
                         input logic [1:0] uhist, input update_op_t uop);
        @(posedge clock);
        #1;
        while (uv && credits == 0) begin  // Hold the update until a credit comes back
            predict_valid = 1'b0;
            update_valid = 1'b0;
            @(posedge clock);
            #1;
        end
        predict_valid = pv;
        predict_index = pidx;
        update_valid = uv;
        update_index = uidx;
        update_history = uhist;
        update_op = uop;
        credits -= uv;
    endtask

    initial begin
        lfsr_state = 32'heb83;
        reset_n = 1'b0;
        predict_valid = 1'b0;
        predict_index = '0;
        update_valid = 1'b0;
        update_index = '0;
        update_history = '0;
        update_op = op_train_taken;
        credits = CREDITS;
        accepted = 0;
        returned = 0;
        value_errors = 0;
        protocol_errors = 0;
        model_history = '0;
        model_miss = '0;
        for (int s = 0; s < `BP_SETS; s++) begin
            model_valid[s] = 1'b0;
            for (int lane = 0; lane < 4; lane++) model_ctr[s][lane] = 2'b00;
        end
        repeat (5) @(posedge clock);
        #1;
        reset_n = 1'b1;

        test_name = "reset_reads";
        for (int i = 0; i < 10; i++) drive(1'b1, pool_index(i % 4), 1'b0, '0, '0, op_train_taken);
        test_name = "saturate";  // Reads alongside each training step
        for (int i = 0; i < 8; i++) drive(1'b1, 9'd6, 1'b1, 9'd6, 2'd2, op_train_taken);
        for (int i = 0; i < 8; i++) drive(1'b1, 9'd6, 1'b1, 9'd6, 2'd2, op_train_not_taken);
        test_name = "history_random";
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            drive(random_bits(1), pool_index(random_bits(2)), random_bits(1),
                  pool_index(random_bits(2)), random_bits(2), random_op());
        end
        test_name = "bypass";  // Read lands in the drain cycle of the write
        for (int i = 0; i < 4; i++) begin
            drive(1'b0, '0, 1'b1, 9'd9, 2'(i), op_train_taken);
            drive(1'b1, 9'd9, 1'b0, '0, '0, op_train_taken);
            repeat (2) drive(1'b0, '0, 1'b0, '0, '0, op_train_taken);
        end
        test_name = "invalidate";
        drive(1'b0, '0, 1'b1, 9'd12, 2'd1, op_train_taken);
        drive(1'b0, '0, 1'b0, '0, '0, op_train_taken);
        drive(1'b1, 9'd12, 1'b0, '0, '0, op_train_taken);
        drive(1'b0, '0, 1'b1, 9'd12, 2'd1, op_invalidate);
        repeat (2) drive(1'b0, '0, 1'b0, '0, '0, op_train_taken);
        repeat (3) drive(1'b1, 9'd12, 1'b0, '0, '0, op_train_taken);
        test_name = "credit_burst";
        for (int b = 0; b < 3; b++) begin
            for (int i = 0; i < 10; i++) begin
                drive(random_bits(1), pool_index(random_bits(2)), 1'b1,
                      pool_index(random_bits(2)), random_bits(2), random_op());
            end
            repeat (6) drive(1'b0, '0, 1'b0, '0, '0, op_train_taken);
        end
        repeat (8) drive(1'b0, '0, 1'b0, '0, '0, op_train_taken);

        assert (credits == CREDITS && accepted == returned)
            else protocol_error("credits not all returned after the queue drained");
        print_counts();
        if (value_errors + protocol_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #((STIM_CYCLES + 100) * 8);
        protocol_error("watchdog expired before the tests finished");
        print_counts();
        $display("Checks failed");
        $finish;
    end

endmodule

/* update_queue.sv */
// Sender must honour credits; the table never stalls, so the head drains every cycle it is valid
`include "bp_config.svh"

module update_queue (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            update_valid,
    input  logic [`BP_INDEX_WIDTH-1:0]      update_index,
    input  logic [`BP_HISTORY_WIDTH-1:0]    update_history,
    input  bp_update_pkg::update_op_t       update_op,
    output logic                            update_credit,
    // Table write port
    output logic                            write_enable,
    output logic [`BP_INDEX_WIDTH-1:0]      write_index,
    output logic [`BP_HISTORY_WIDTH-1:0]    write_counter_select,
    output logic                            write_inc,
    output logic                            write_dec,
    output logic                            valid_in,
    // Resolved direction for the global history
    output logic                            train_taken_pulse,
    output logic                            train_taken
);

    import bp_update_pkg::*;

    localparam int DEPTH = `BP_UPDATE_CREDITS;
    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);
    localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(DEPTH);

    logic [`BP_INDEX_WIDTH-1:0]   fifo_index   [DEPTH];
    logic [`BP_HISTORY_WIDTH-1:0] fifo_history [DEPTH];
    update_op_t                   fifo_op      [DEPTH];

    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   push;
    logic                   pop;
    update_op_t             head_op;

    // Wraps correctly for depths that are not a power of two
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push = update_valid;
    assign pop  = (count != '0);  // Drain whenever anything is held

    always_ff @(posedge clock) begin
        if (push) begin
            fifo_index[wr_ptr]   <= update_index;
            fifo_history[wr_ptr] <= update_history;
            fifo_op[wr_ptr]      <= update_op;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            count <= count + COUNT_WIDTH'(push) - COUNT_WIDTH'(pop);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Head decode into table write controls
    ////////////////////////////////////////////////////////////////////////////

    assign head_op              = fifo_op[rd_ptr];
    assign write_enable         = pop;
    assign update_credit        = pop;   // Slot frees in the drain cycle
    assign write_index          = fifo_index[rd_ptr];
    assign write_counter_select = fifo_history[rd_ptr];

    always_comb begin
        case (head_op)
            op_train_taken: begin
                write_inc = 1'b1;
                write_dec = 1'b0;
                valid_in  = 1'b1;
            end
            op_train_not_taken: begin
                write_inc = 1'b0;
                write_dec = 1'b1;
                valid_in  = 1'b1;
            end
            default: begin           // Invalidate, counter held by inc and dec together
                write_inc = 1'b1;
                write_dec = 1'b1;
                valid_in  = 1'b0;
            end
        endcase
    end

    assign train_taken_pulse = pop && op_trains(head_op);
    assign train_taken       = (head_op == op_train_taken);

    // Credit loop broken if the sender pushes into a full queue
    assert property (@(posedge clock) disable iff (!reset_n)
        update_valid |-> (count != FULL_COUNT))
        else $error("update_queue: update received while full");

    assert property (@(posedge clock) disable iff (!reset_n) count <= FULL_COUNT)
        else $error("update_queue: occupancy above depth");

endmodule
